// File: design/idu_pkg.sv
package idu_pkg;

  // datapath width and register index width (rv32e has 16 registers)
  localparam int xlen      = 32;
  localparam int reg_idx_w = 4;
  localparam int nregs     = 1 << reg_idx_w;

  // base opcodes, inst[6:0]
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_auipc   = 7'b0010111;
  localparam logic [6:0] op_jal     = 7'b1101111;
  localparam logic [6:0] op_jalr    = 7'b1100111;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_load    = 7'b0000011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_op_imm  = 7'b0010011;
  localparam logic [6:0] op_op      = 7'b0110011;
  localparam logic [6:0] op_system  = 7'b1110011;
  localparam logic [6:0] op_fence_i = 7'b0001111;

  // alu codes are {funct7[5], funct3} for the arithmetic ops
  localparam logic [3:0] alu_add  = 4'b0000;
  localparam logic [3:0] alu_sll  = 4'b0001;
  localparam logic [3:0] alu_slt  = 4'b0010;
  localparam logic [3:0] alu_sltu = 4'b0011;
  localparam logic [3:0] alu_xor  = 4'b0100;
  localparam logic [3:0] alu_srl  = 4'b0101;
  localparam logic [3:0] alu_or   = 4'b0110;
  localparam logic [3:0] alu_and  = 4'b0111;
  localparam logic [3:0] alu_sub  = 4'b1000;
  localparam logic [3:0] alu_sra  = 4'b1101;
  // branch compares, placed in codes the arithmetic ops leave free
  localparam logic [3:0] alu_sle  = 4'b1010;
  localparam logic [3:0] alu_sleu = 4'b1011;

  // the one ebreak encoding
  localparam logic [31:0] inst_ebreak = 32'h0010_0073;

  // fetch payload
  typedef struct packed {
    logic [31:0]     inst;
    logic [xlen-1:0] pc;
  } fetch_t;

  // writeback bus, always accepted
  typedef struct packed {
    logic                 valid;
    logic [reg_idx_w-1:0] rd;
    logic [xlen-1:0]      data;
  } wb_t;

  // scoreboard set request from an accepted issue
  typedef struct packed {
    logic                 en;
    logic [reg_idx_w-1:0] rd;
  } sb_set_t;

  typedef struct packed {
    logic ren;
    logic wen;
    logic en_j;
    logic ebreak;
    logic csr_wen;
    logic system;
    logic system_func3_zero;
  } issue_flags_t;

  typedef struct packed {
    logic [xlen-1:0]      pc;
    logic [31:0]          inst;
    logic [xlen-1:0]      op1;
    logic [xlen-1:0]      op2;
    logic [31:0]          imm;
    // effective address of a load or store
    logic [xlen-1:0]      rwaddr;
    // jump or branch base
    logic [xlen-1:0]      op_j;
    logic [reg_idx_w-1:0] rd;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [3:0]           alu_op;
    issue_flags_t         flags;
    logic                 writes_rd;
  } issue_t;

endpackage

// File: design/idu_decoder.sv
module idu_decoder import idu_pkg::*; (
  input  logic [31:0]     inst_i,
  input  logic [xlen-1:0] pc_i,
  input  logic [xlen-1:0] rs1v_i,
  input  logic [xlen-1:0] rs2v_i,
  output issue_t          decoded_o
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        funct7_b5;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic        br_swap;
  logic [3:0]  br_alu;
  logic        wr_cls;

  assign opcode    = inst_i[6:0];
  assign funct3    = inst_i[14:12];
  assign funct7_b5 = inst_i[30];

  // immediates for every format, sign extended
  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                  inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};

  // bge and bgeu compare the other way round, so the alu only needs sle
  assign br_swap = funct3[2] & funct3[0];

  always_comb begin
    case (funct3)
      3'b000:  br_alu = alu_sub;
      3'b001:  br_alu = alu_xor;
      3'b100:  br_alu = alu_slt;
      3'b101:  br_alu = alu_sle;
      3'b110:  br_alu = alu_sltu;
      3'b111:  br_alu = alu_sleu;
      default: br_alu = alu_add;
    endcase
  end

  always_comb begin
    // unknown opcodes fall out as an add with all flags low
    decoded_o        = '0;
    decoded_o.pc     = pc_i;
    decoded_o.inst   = inst_i;
    decoded_o.rd     = inst_i[10:7];
    decoded_o.rs1    = inst_i[18:15];
    decoded_o.rs2    = inst_i[23:20];
    decoded_o.alu_op = alu_add;
    wr_cls           = 1'b0;
    case (opcode)
      op_lui: begin
        decoded_o.imm = imm_u;
        decoded_o.op2 = imm_u;
        wr_cls        = 1'b1;
      end
      op_auipc: begin
        decoded_o.imm = imm_u;
        decoded_o.op1 = pc_i;
        decoded_o.op2 = imm_u;
        wr_cls        = 1'b1;
      end
      op_jal: begin
        // link value pc + 4 goes through the alu
        decoded_o.imm        = imm_j;
        decoded_o.op1        = pc_i;
        decoded_o.op2        = xlen'(4);
        decoded_o.op_j       = pc_i;
        decoded_o.flags.en_j = 1'b1;
        wr_cls               = 1'b1;
      end
      op_jalr: begin
        decoded_o.imm        = imm_i;
        decoded_o.op1        = pc_i;
        decoded_o.op2        = xlen'(4);
        decoded_o.op_j       = rs1v_i;
        decoded_o.flags.en_j = 1'b1;
        wr_cls               = 1'b1;
      end
      op_branch: begin
        decoded_o.imm        = imm_b;
        decoded_o.op1        = br_swap ? rs2v_i : rs1v_i;
        decoded_o.op2        = br_swap ? rs1v_i : rs2v_i;
        decoded_o.op_j       = pc_i;
        decoded_o.alu_op     = br_alu;
        decoded_o.flags.en_j = 1'b1;
      end
      op_load: begin
        decoded_o.imm       = imm_i;
        decoded_o.op1       = rs1v_i;
        decoded_o.op2       = imm_i;
        decoded_o.rwaddr    = rs1v_i + imm_i;
        decoded_o.alu_op    = {1'b0, funct3};
        decoded_o.flags.ren = 1'b1;
        wr_cls              = 1'b1;
      end
      op_store: begin
        decoded_o.imm       = imm_s;
        decoded_o.op1       = rs1v_i;
        decoded_o.op2       = rs2v_i;
        decoded_o.rwaddr    = rs1v_i + imm_s;
        decoded_o.alu_op    = {1'b0, funct3};
        decoded_o.flags.wen = 1'b1;
      end
      op_op_imm: begin
        decoded_o.imm    = imm_i;
        decoded_o.op1    = rs1v_i;
        decoded_o.op2    = imm_i;
        // only the shifts carry funct7[5], elsewhere it is immediate
        decoded_o.alu_op = {(funct3 == 3'b101) ? funct7_b5 : 1'b0, funct3};
        wr_cls           = 1'b1;
      end
      op_op: begin
        decoded_o.op1    = rs1v_i;
        decoded_o.op2    = rs2v_i;
        decoded_o.alu_op = {funct7_b5, funct3};
        wr_cls           = 1'b1;
      end
      op_system: begin
        // imm holds the csr address or the ecall/ebreak/mret code
        decoded_o.imm                     = imm_i;
        decoded_o.op1                     = rs1v_i;
        decoded_o.alu_op                  = {1'b0, funct3};
        decoded_o.flags.system            = 1'b1;
        decoded_o.flags.system_func3_zero = (funct3 == 3'b000);
        decoded_o.flags.csr_wen           = (funct3 != 3'b000);
        decoded_o.flags.ebreak            = (inst_i == inst_ebreak);
        wr_cls                            = 1'b1;
      end
      op_fence_i: begin
        decoded_o.imm          = imm_i;
        decoded_o.flags.system = 1'b1;
        wr_cls                 = 1'b1;
      end
      default: begin
      end
    endcase
    // x0 is never a destination
    decoded_o.writes_rd = wr_cls & (decoded_o.rd != '0);
  end

endmodule

// File: design/idu_stage.sv
module idu_stage import idu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  fetch_t               fetch_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  logic                 issue_ready_i,
  input  wb_t                  wb_i,
  input  logic [xlen-1:0]      rdata1_i,
  input  logic [xlen-1:0]      rdata2_i,
  input  logic [nregs-1:0]     busy_i,
  output logic [reg_idx_w-1:0] raddr1_o,
  output logic [reg_idx_w-1:0] raddr2_o,
  output issue_t               issue_o,
  output logic                 issue_valid_o,
  output sb_set_t              issue_fire_o
);

  // latched fetch pair
  fetch_t               cur_q;
  logic                 valid_q;
  logic [6:0]           opcode;
  logic [reg_idx_w-1:0] rs1;
  logic [reg_idx_w-1:0] rs2;
  logic                 fwd1;
  logic                 fwd2;
  logic [xlen-1:0]      rs1v;
  logic [xlen-1:0]      rs2v;
  logic                 no_src;
  logic                 hazard;
  logic                 issue_fire;

  assign opcode = cur_q.inst[6:0];
  assign rs1    = cur_q.inst[18:15];
  assign rs2    = cur_q.inst[23:20];

  assign raddr1_o = rs1;
  assign raddr2_o = rs2;

  // a writeback in flight this cycle overrides the register file
  assign fwd1 = wb_i.valid & (wb_i.rd != '0) & (wb_i.rd == rs1);
  assign fwd2 = wb_i.valid & (wb_i.rd != '0) & (wb_i.rd == rs2);
  assign rs1v = fwd1 ? wb_i.data : rdata1_i;
  assign rs2v = fwd2 ? wb_i.data : rdata2_i;

  // lui, auipc and jal read no register, their rs fields are immediate bits
  assign no_src = (opcode == op_lui) | (opcode == op_auipc) | (opcode == op_jal);

  // busy source not rescued by this cycle's writeback
  assign hazard = valid_q & ~no_src &
                  ((busy_i[rs1] & ~fwd1) | (busy_i[rs2] & ~fwd2));

  assign issue_valid_o = valid_q & ~hazard;
  assign issue_fire    = issue_valid_o & issue_ready_i;

  // take a new pair when empty or when the current one leaves now
  assign fetch_ready_o = ~valid_q | issue_fire;

  idu_decoder u_decoder (
    .inst_i    (cur_q.inst),
    .pc_i      (cur_q.pc),
    .rs1v_i    (rs1v),
    .rs2v_i    (rs2v),
    .decoded_o (issue_o)
  );

  // scoreboard marks rd busy on the accepting edge
  assign issue_fire_o.en = issue_fire & issue_o.writes_rd;
  assign issue_fire_o.rd = issue_o.rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (fetch_ready_o) begin
      valid_q <= fetch_valid_i;
    end
  end

  // payload held while the stage is stalled or back-pressured
  always_ff @(posedge clk) begin
    if (fetch_valid_i && fetch_ready_o) begin
      cur_q <= fetch_i;
    end
  end

endmodule

// File: design/idu_regfile.sv
module idu_regfile import idu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [reg_idx_w-1:0] raddr1_i,
  input  logic [reg_idx_w-1:0] raddr2_i,
  input  wb_t                  wb_i,
  output logic [xlen-1:0]      rdata1_o,
  output logic [xlen-1:0]      rdata2_o
);

  logic [xlen-1:0] regs_q [nregs];

  // asynchronous reads, x0 reads as zero whatever the array holds
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < nregs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_i.valid && wb_i.rd != '0) begin
      // writes to x0 are dropped
      regs_q[wb_i.rd] <= wb_i.data;
    end
  end

endmodule

// File: design/idu_scoreboard.sv
module idu_scoreboard import idu_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  sb_set_t          set_i,
  input  wb_t              wb_i,
  output logic [nregs-1:0] busy_o
);

  logic [nregs-1:0] busy_q;
  logic [nregs-1:0] busy_d;

  assign busy_o = busy_q;

  always_comb begin
    busy_d = busy_q;
    // writeback retires the register
    if (wb_i.valid) begin
      busy_d[wb_i.rd] = 1'b0;
    end
    // a new producer issued in the same cycle keeps it busy
    if (set_i.en) begin
      busy_d[set_i.rd] = 1'b1;
    end
    // x0 never has a pending producer
    busy_d[0] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

endmodule

// File: design/idu_top.sv
module idu_top import idu_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  fetch_t fetch_i,
  input  logic   fetch_valid_i,
  output logic   fetch_ready_o,
  output issue_t issue_o,
  output logic   issue_valid_o,
  input  logic   issue_ready_i,
  input  wb_t    wb_i
);

  // register file read path
  logic [reg_idx_w-1:0] raddr1;
  logic [reg_idx_w-1:0] raddr2;
  logic [xlen-1:0]      rdata1;
  logic [xlen-1:0]      rdata2;
  // scoreboard path
  logic [nregs-1:0]     busy;
  sb_set_t              issue_fire;

  idu_stage u_stage (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .issue_ready_i (issue_ready_i),
    .wb_i          (wb_i),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .busy_i        (busy),
    .raddr1_o      (raddr1),
    .raddr2_o      (raddr2),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o),
    .issue_fire_o  (issue_fire)
  );

  idu_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .wb_i     (wb_i),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  idu_scoreboard u_scoreboard (
    .clk    (clk),
    .rst    (rst),
    .set_i  (issue_fire),
    .wb_i   (wb_i),
    .busy_o (busy)
  );

endmodule

// File: sim/idu_monitor.sv
module idu_monitor import idu_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  issue_t issue_i,
  input  logic   issue_valid_i,
  input  logic   issue_ready_i,
  input  wb_t    wb_i,
  output int     issued_o,
  output int     errors_o,
  output int     failed_o
);

  // expected view of one issue record, as listed in the tests file
  typedef struct packed {
    logic [31:0]  inst;
    logic [31:0]  pc;
    logic [31:0]  op1;
    logic [31:0]  op2;
    logic [31:0]  imm;
    logic [3:0]   rd;
    logic [3:0]   alu_op;
    issue_flags_t flags;
  } exp_t;

  exp_t exp_q[$];

  // register contents as the writeback bus leaves them
  logic [xlen-1:0] shadow_q [nregs];

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < nregs; i++) begin
        shadow_q[i] <= '0;
      end
    end else if (wb_i.valid && wb_i.rd != '0) begin
      shadow_q[wb_i.rd] <= wb_i.data;
    end
  end

  // value of a source register at issue, a writeback in the same cycle included
  function automatic logic [31:0] source_value(input logic [3:0] idx);
    if (idx == '0) begin
      return '0;
    end
    if (wb_i.valid && wb_i.rd == idx) begin
      return wb_i.data;
    end
    return shadow_q[idx];
  endfunction

  task automatic add_expected(input exp_t e);
    exp_q.push_back(e);
  endtask

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got_v, inout bit ok);
    if (got_v !== exp_v) begin
      $display("** Error at time %0t: issue_o.%s expected %h got %h",
               $time, name, exp_v, got_v);
      errors_o++;
      ok = 1'b0;
    end
  endtask

  // handshake sampled mid-cycle, the transfer happens on the next rising edge
  always @(negedge clk) begin : sample
    exp_t        e;
    bit          ok;
    logic [31:0] exp_j;
    if (rst) begin
      issued_o = 0;
      errors_o = 0;
      failed_o = 0;
    end else if (issue_valid_i && issue_ready_i) begin
      if (issued_o >= exp_q.size()) begin
        $display("unexpected issue of inst %h at time %0t, past the end of the test list",
                 issue_i.inst, $time);
        errors_o++;
      end else begin
        e  = exp_q[issued_o];
        ok = 1'b1;
        check_field("inst", e.inst, issue_i.inst, ok);
        check_field("pc", e.pc, issue_i.pc, ok);
        check_field("op1", e.op1, issue_i.op1, ok);
        check_field("op2", e.op2, issue_i.op2, ok);
        check_field("imm", e.imm, issue_i.imm, ok);
        check_field("rd", 32'(e.rd), 32'(issue_i.rd), ok);
        check_field("alu_op", 32'(e.alu_op), 32'(issue_i.alu_op), ok);
        check_field("flags", 32'(e.flags), 32'(issue_i.flags), ok);
        // memory ops carry base plus offset, base is op1 there
        if (e.flags.ren || e.flags.wen) begin
          check_field("rwaddr", e.op1 + e.imm, issue_i.rwaddr, ok);
        end
        // jalr jumps from rs1 and the others from their own pc
        if (e.flags.en_j) begin
          exp_j = (e.inst[6:0] == op_jalr) ? source_value(e.inst[18:15]) : e.pc;
          check_field("op_j", exp_j, issue_i.op_j, ok);
        end
        if (!ok) begin
          failed_o++;
        end
        $display("test %0d pc %h inst %h: %s", issued_o, e.pc, e.inst,
                 ok ? "ok" : "FAILED");
      end
      issued_o++;
    end
  end

  task automatic print_summary();
    $display("tests %0d issued %0d failed %0d errors %0d",
             exp_q.size(), issued_o, failed_o, errors_o);
  endtask

endmodule

// File: sim/idu_chk.sv
module idu_chk import idu_pkg::*; (
  input logic             clk,
  input logic             rst,
  input issue_t           issue_i,
  input logic             issue_valid_i,
  input logic             issue_ready_i,
  input logic [nregs-1:0] busy_i,
  input wb_t              wb_i,
  input logic             fetch_ready_i
);

  // failed assertion count
  int   fails = 0;
  logic reads_rs;
  logic rs1_pending;
  logic rs2_pending;

  // lui, auipc and jal carry immediate bits in their rs fields
  assign reads_rs = (issue_i.inst[6:0] != op_lui) && (issue_i.inst[6:0] != op_auipc) &&
                    (issue_i.inst[6:0] != op_jal);

  // busy source that this cycle's writeback does not deliver
  assign rs1_pending = busy_i[issue_i.rs1] && !(wb_i.valid && wb_i.rd == issue_i.rs1);
  assign rs2_pending = busy_i[issue_i.rs2] && !(wb_i.valid && wb_i.rd == issue_i.rs2);

  // record under back-pressure holds, operand fields may take a forward
  property issue_stable;
    @(posedge clk) disable iff (rst)
      (issue_valid_i && !issue_ready_i) |=> issue_valid_i &&
        $stable({issue_i.pc, issue_i.inst, issue_i.imm, issue_i.rd,
                 issue_i.alu_op, issue_i.flags, issue_i.writes_rd});
  endproperty

  a_issue_stable: assert property (issue_stable)
    else begin
      $error("issue record changed under back-pressure");
      fails++;
    end

  a_no_issue_on_hazard: assert property (
    @(posedge clk) disable iff (rst)
      (issue_valid_i && reads_rs) |-> (!rs1_pending && !rs2_pending))
    else begin
      $error("issue valid while a source register is busy");
      fails++;
    end

  a_ready_after_reset: assert property (
    @(posedge clk) $fell(rst) |-> fetch_ready_i)
    else begin
      $error("fetch not ready in the first cycle after reset");
      fails++;
    end

endmodule

bind idu_stage idu_chk u_chk (
  .clk           (clk),
  .rst           (rst),
  .issue_i       (issue_o),
  .issue_valid_i (issue_valid_o),
  .issue_ready_i (issue_ready_i),
  .busy_i        (busy_i),
  .wb_i          (wb_i),
  .fetch_ready_i (fetch_ready_o)
);

// File: include/idu_defs.svh
`ifndef IDU_DEFS_SVH
`define IDU_DEFS_SVH

// line kinds of the tests file
`define IDU_TAG_FETCH "F"
`define IDU_TAG_WB    "W"

// F line, in this order: inst pc op1 op2 imm rd alu_op flags
`define IDU_F_FIELDS 8
`define IDU_F_FMT    "F %h %h %h %h %h %h %h %h"

// W line: rd data, then the issue count to wait for
`define IDU_W_FIELDS 3
`define IDU_W_FMT    "W %h %h %d"

`endif

// File: sim/idu_tb.sv
`include "idu_defs.svh"

module idu_tb import idu_pkg::*; ();

  logic        clk;
  logic        rst;
  fetch_t      fetch;
  logic        fetch_valid;
  logic        fetch_ready;
  issue_t      issue;
  logic        issue_valid;
  logic        issue_ready;
  wb_t         wb;
  logic [31:0] lfsr = 32'h3d75;

  // loaded stimulus
  fetch_t fetch_q[$];
  wb_t    wb_q[$];
  int     wb_after_q[$];
  int     n_lines;
  int     load_errors;
  bit     loaded;
  int     issued;
  int     errors;
  int     failed;

  idu_top dut (
    .clk           (clk),
    .rst           (rst),
    .fetch_i       (fetch),
    .fetch_valid_i (fetch_valid),
    .fetch_ready_o (fetch_ready),
    .issue_o       (issue),
    .issue_valid_o (issue_valid),
    .issue_ready_i (issue_ready),
    .wb_i          (wb)
  );

  idu_monitor mon (
    .clk           (clk),
    .rst           (rst),
    .issue_i       (issue),
    .issue_valid_i (issue_valid),
    .issue_ready_i (issue_ready),
    .wb_i          (wb),
    .issued_o      (issued),
    .errors_o      (errors),
    .failed_o      (failed)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // random back-pressure on the issue port
  always @(posedge clk) begin
    #2;
    lfsr = lfsr_step(lfsr);
    issue_ready = lfsr[0];
  end

  task automatic load_tests();
    int             fd;
    int             n;
    int             after;
    string          line;
    logic [31:0]    inst;
    logic [31:0]    pc;
    logic [31:0]    op1;
    logic [31:0]    op2;
    logic [31:0]    imm;
    logic [3:0]     rd;
    logic [3:0]     alu;
    logic [6:0]     flags;
    logic [31:0]    data;
    fetch_t         f;
    wb_t            w;
    fd = $fopen("sim/idu_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open sim/idu_tests.txt");
      load_errors++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      n_lines++;
      if (line.substr(0, 0) == `IDU_TAG_FETCH) begin
        n = $sscanf(line, `IDU_F_FMT, inst, pc, op1, op2, imm, rd, alu, flags);
        if (n != `IDU_F_FIELDS) begin
          $display("malformed fetch line in tests file: %s", line);
          load_errors++;
        end else begin
          f.inst = inst;
          f.pc   = pc;
          fetch_q.push_back(f);
          mon.add_expected({inst, pc, op1, op2, imm, rd, alu, flags});
        end
      end else if (line.substr(0, 0) == `IDU_TAG_WB) begin
        n = $sscanf(line, `IDU_W_FMT, rd, data, after);
        if (n != `IDU_W_FIELDS) begin
          $display("malformed writeback line in tests file: %s", line);
          load_errors++;
        end else begin
          w.valid = 1'b1;
          w.rd    = rd;
          w.data  = data;
          wb_q.push_back(w);
          wb_after_q.push_back(after);
        end
      end else begin
        $display("unknown line kind in tests file: %s", line);
        load_errors++;
      end
    end
    $fclose(fd);
  endtask

  // one pair per handshake, ready sampled where it is stable
  task automatic drive_fetch();
    bit accepted;
    foreach (fetch_q[i]) begin
      fetch       = fetch_q[i];
      fetch_valid = 1'b1;
      do begin
        @(negedge clk);
        accepted = fetch_ready;
        @(posedge clk);
        #2;
      end while (!accepted);
    end
    fetch_valid = 1'b0;
  endtask

  // each writeback waits for its issue count, then pulses for one cycle
  task automatic drive_wb();
    foreach (wb_q[i]) begin
      while (issued < wb_after_q[i]) begin
        @(posedge clk);
        #2;
      end
      wb = wb_q[i];
      @(posedge clk);
      #2;
      wb = '0;
    end
  endtask

  initial begin
    rst         = 1'b1;
    fetch       = '0;
    fetch_valid = 1'b0;
    issue_ready = 1'b0;
    wb          = '0;
    n_lines     = 0;
    load_errors = 0;
    load_tests();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    fork
      drive_fetch();
      drive_wb();
    join
    while (issued < fetch_q.size()) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    mon.print_summary();
    if (load_errors == 0 && errors == 0 && failed == 0 &&
        dut.u_stage.u_chk.fails == 0 && issued == fetch_q.size()) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog, 40 cycles per tests-file line
  initial begin
    wait (loaded);
    #(n_lines * 40 * 40);
    $display("timeout: issue stream did not finish, %0d issued of %0d",
             issued, fetch_q.size());
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: sim/idu_tests.txt
# F inst pc op1 op2 imm rd alu_op flags (flags: ren wen en_j ebreak csr_wen system f3zero)
# W rd data issues_before_write
W 1 00000010 0
W 2 00000005 0
W 3 fffffff0 0
F 12345237 00000100 00000000 12345000 12345000 4 0 00
F 00001297 00000104 00000104 00001000 00001000 5 0 00
F 0080036f 00000108 00000108 00000004 00000008 6 0 10
F 000203b7 0000010c 00000000 00020000 00020000 7 0 00
F ffd08413 00000110 00000010 fffffffd fffffffd 8 0 00
F 002084b3 00000114 00000010 00000005 00000000 9 0 00
F 40110533 00000118 00000005 00000010 00000000 a 8 00
F 4021d593 0000011c fffffff0 00000402 00000402 b d 00
F 00c0a603 00000120 00000010 0000000c 0000000c c 2 40
F fe21ae23 00000124 fffffff0 00000005 fffffffc c 2 20
F 0020d863 00000128 00000005 00000010 00000010 0 a 10
F 000106e7 0000012c 0000012c 00000004 00000000 d 0 10
W 9 00000077 12
F 00148733 00000130 00000077 00000010 00000000 e 0 00
F 00100073 00000134 00000000 00000000 00000001 0 0 0b
F 300097f3 00000138 00000010 00000000 00000300 f 1 06
F 0000100f 0000013c 00000000 00000000 00000000 0 0 02
W e 000000a5 16
F 000741b3 00000140 000000a5 00000000 00000000 3 4 00

// File: compile.f
+incdir+include
design/idu_pkg.sv
design/idu_decoder.sv
design/idu_stage.sv
design/idu_regfile.sv
design/idu_scoreboard.sv
design/idu_top.sv
sim/idu_monitor.sv
sim/idu_chk.sv
sim/idu_tb.sv

// File: Bender.yml
package:
  name: idu

sources:
  - include_dirs:
      - include
    files:
      - design/idu_pkg.sv
      - design/idu_decoder.sv
      - design/idu_stage.sv
      - design/idu_regfile.sv
      - design/idu_scoreboard.sv
      - design/idu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/idu_monitor.sv
      - sim/idu_chk.sv
      - sim/idu_tb.sv
